// ==== mp_mem_top.f ====
+incdir+verilog
verilog/mp_mem_pkg.sv
verilog/mp_port_pkg.sv
verilog/mp_write_steer.sv
verilog/mp_sram_1r1w.sv
verilog/mp_bank_array.sv
verilog/mp_read_return.sv
verilog/mp_mem_top.sv
tb/mp_mem_assertions.sv
tb/mp_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mp_mem_tb \
  -f mp_mem_top.f -o mp_mem_sim \
  && ./obj_dir/mp_mem_sim | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }

// ==== tb/mp_mem_assertions.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_mem_assertions (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               ready,
  input  mp_port_pkg::wr_req_t    wr_req [`MP_NUMWRPT],
  input  mp_port_pkg::rd_req_t    rd_req [`MP_NUMRDPT],
  input  mp_port_pkg::bank_wr_t   bank_wr [`MP_NUMVBNK],
  input  wire logic [`MP_NUMRDPT-1:0] rd_vld
);

  mp_port_pkg::bank_wr_t exp_wr [`MP_NUMVBNK];

  // Winning write per bank, first matching port from port 0 up.
  always_comb begin
    logic found;
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      exp_wr[b] = '0;
      found = 1'b0;
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        if (!found && wr_req[p].write && wr_req[p].bank == mp_mem_pkg::bank_t'(b)) begin
          exp_wr[b].en   = 1'b1;
          exp_wr[b].row  = wr_req[p].row;
          exp_wr[b].data = wr_req[p].data;
          found = 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < `MP_NUMRDPT; p++) begin : g_rd
    a_vld_latency: assert property (@(posedge clk) disable iff (reset)
      rd_vld[p] == $past(ready && rd_req[p].read, 2))
      else $error("rd_vld on read port %0d does not follow its strobe by two cycles", p);
  end

  a_no_vld_clearing: assert property (@(posedge clk) disable iff (reset)
    !ready |-> (rd_vld == '0))
    else $error("rd_vld high while the memory is still clearing");

  a_ready_hold: assert property (@(posedge clk) disable iff (reset)
    !$fell(ready))
    else $error("ready fell without reset");

  for (genvar b = 0; b < `MP_NUMVBNK; b++) begin : g_bank
    a_bank_write: assert property (@(posedge clk) disable iff (reset)
      ready |-> (bank_wr[b] == exp_wr[b]))
      else $error("bank %0d write command does not match the winning port", b);
  end

endmodule

bind mp_mem_top mp_mem_assertions u_assertions (
  .clk     (clk),
  .reset   (reset),
  .ready   (ready),
  .wr_req  (wr_req),
  .rd_req  (rd_req),
  .bank_wr (bank_wr),
  .rd_vld  (rd_vld)
);

`default_nettype wire

// ==== tb/mp_mem_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_mem_tb;

  localparam int clk_period = 4;
  localparam int num_rand   = 200;
  localparam int drain_max  = 16;

  // Rough cycle budget of all tests, used by the watchdog.
  localparam int test_cycles = 4 + 4 + 2 * `MP_NUMVROW + `MP_NUMVBNK * `MP_NUMVROW
                               + 12 + num_rand + 6 * (drain_max + 1);
  localparam int timeout_ns  = (test_cycles + 100) * clk_period;

  // Expected read result, due in a given cycle on a given port.
  typedef struct packed {
    int                port;
    int                due;
    mp_mem_pkg::data_t data;
  } rd_entry_t;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       ready;
  mp_port_pkg::wr_req_t       wr_req [`MP_NUMWRPT];
  mp_port_pkg::rd_req_t       rd_req [`MP_NUMRDPT];
  logic [`MP_NUMRDPT-1:0]     rd_vld;
  mp_mem_pkg::data_t          rd_dout [`MP_NUMRDPT];

  mp_mem_pkg::data_t ref_mem [`MP_NUMVBNK][`MP_NUMVROW];
  rd_entry_t         exp_q [$];
  int                cyc = 0;
  int                errors = 0;
  int                checks = 0;
  integer            seed = 32'h8cbad24a;

  mp_mem_top mp_mem_top_i (
    .clk     (clk),
    .reset   (reset),
    .ready   (ready),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_data(input string what, input mp_mem_pkg::data_t expected,
                            input mp_mem_pkg::data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s, expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  function automatic mp_port_pkg::wr_req_t make_write(input mp_mem_pkg::bank_t bank,
                                                     input mp_mem_pkg::row_t row,
                                                     input mp_mem_pkg::data_t data);
    mp_port_pkg::wr_req_t w;
    w.write = 1'b1;
    w.bank  = bank;
    w.row   = row;
    w.data  = data;
    return w;
  endfunction

  function automatic mp_port_pkg::rd_req_t make_read(input mp_mem_pkg::bank_t bank,
                                                    input mp_mem_pkg::row_t row);
    mp_port_pkg::rd_req_t r;
    r.read = 1'b1;
    r.bank = bank;
    r.row  = row;
    return r;
  endfunction

  // Drives one cycle of requests and updates the model. Reads see the old word.
  task automatic issue_cycle(input mp_port_pkg::wr_req_t w [`MP_NUMWRPT],
                             input mp_port_pkg::rd_req_t r [`MP_NUMRDPT]);
    logic [`MP_NUMVBNK-1:0] taken;
    rd_entry_t              e;
    wr_req = w;
    rd_req = r;
    if (ready) begin
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        if (r[p].read) begin
          e.port = p;
          e.due  = cyc + 2;
          e.data = ref_mem[r[p].bank][r[p].row];
          exp_q.push_back(e);
        end
      end
      // Lowest port wins a bank.
      taken = '0;
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        if (w[p].write && !taken[w[p].bank]) begin
          ref_mem[w[p].bank][w[p].row] = w[p].data;
          taken[w[p].bank] = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    for (int p = 0; p < `MP_NUMWRPT; p++) w[p] = '0;
    for (int p = 0; p < `MP_NUMRDPT; p++) r[p] = '0;
    issue_cycle(w, r);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < drain_max) begin
      idle_cycle();
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("Read results still outstanding after %0d idle cycles", drain_max);
    end
    idle_cycle();
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < 4 * `MP_NUMVROW) begin
      idle_cycle();
      n++;
    end
    if (!ready) begin
      errors++;
      $display("Ready did not rise after the clear sequence");
    end
  endtask

  task automatic test_clear();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    check_flag("ready after reset", 1'b0, ready);
    idle_cycle();
    // Row 0 is already cleared here, so an accepted write would stick.
    w[0] = make_write(2'd1, 4'd0, 16'hdead);
    w[1] = '0;
    r[0] = make_read(2'd1, 4'd0);
    r[1] = '0;
    issue_cycle(w, r);
    wait_ready();
    check_flag("ready after clear", 1'b1, ready);
    w[0] = '0;
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      for (int row = 0; row < `MP_NUMVROW; row++) begin
        r[0] = make_read(mp_mem_pkg::bank_t'(b), mp_mem_pkg::row_t'(row));
        r[1] = r[0];
        issue_cycle(w, r);
      end
    end
    drain();
  endtask

  task automatic test_basic();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    w[0] = make_write(2'd2, 4'd6, 16'h1234);
    w[1] = '0;
    r[0] = '0;
    r[1] = '0;
    issue_cycle(w, r);
    w[0] = '0;
    r[0] = make_read(2'd2, 4'd6);
    r[1] = make_read(2'd2, 4'd6);
    issue_cycle(w, r);
    drain();
  endtask

  task automatic test_parallel();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    w[0] = make_write(2'd0, 4'd9, 16'h0a0a);
    w[1] = make_write(2'd3, 4'd2, 16'h5b5b);
    r[0] = '0;
    r[1] = '0;
    issue_cycle(w, r);
    w[0] = '0;
    w[1] = '0;
    r[0] = make_read(2'd0, 4'd9);
    r[1] = make_read(2'd3, 4'd2);
    issue_cycle(w, r);
    drain();
  endtask

  task automatic test_priority();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    w[0] = make_write(2'd1, 4'd11, 16'h7777);
    w[1] = '0;
    r[0] = '0;
    r[1] = '0;
    issue_cycle(w, r);
    w[0] = make_write(2'd1, 4'd4, 16'hc0de);
    w[1] = make_write(2'd1, 4'd11, 16'hbad0);
    issue_cycle(w, r);
    w[0] = '0;
    w[1] = '0;
    r[0] = make_read(2'd1, 4'd4);
    r[1] = make_read(2'd1, 4'd11);
    issue_cycle(w, r);
    drain();
  endtask

  task automatic test_rdw_back_to_back();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    w[0] = make_write(2'd3, 4'd7, 16'h1111);
    w[1] = '0;
    r[0] = '0;
    r[1] = '0;
    issue_cycle(w, r);
    w[0] = make_write(2'd3, 4'd7, 16'h2222);
    r[0] = make_read(2'd3, 4'd7);
    r[1] = make_read(2'd0, 4'd9);
    issue_cycle(w, r);
    w[0] = '0;
    r[1] = make_read(2'd2, 4'd6);
    issue_cycle(w, r);
    r[1] = make_read(2'd3, 4'd7);
    issue_cycle(w, r);
    drain();
  endtask

  task automatic test_random();
    mp_port_pkg::wr_req_t w [`MP_NUMWRPT];
    mp_port_pkg::rd_req_t r [`MP_NUMRDPT];
    for (int i = 0; i < num_rand; i++) begin
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        w[p] = make_write(mp_mem_pkg::bank_t'($random(seed)),
                          mp_mem_pkg::row_t'($random(seed)),
                          mp_mem_pkg::data_t'($random(seed)));
        w[p].write = 1'($random(seed));
      end
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        r[p] = make_read(mp_mem_pkg::bank_t'($random(seed)),
                         mp_mem_pkg::row_t'($random(seed)));
        r[p].read = 1'($random(seed));
      end
      issue_cycle(w, r);
    end
    drain();
  endtask

  // Checks every cycle that rd_vld is high exactly when a result is due.
  always @(negedge clk) begin : monitor
    logic [`MP_NUMRDPT-1:0] want;
    mp_mem_pkg::data_t      want_data [`MP_NUMRDPT];
    rd_entry_t              head;
    if (!reset) begin
      want = '0;
      while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
        head = exp_q.pop_front();
        want[head.port] = 1'b1;
        want_data[head.port] = head.data;
      end
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        check_flag($sformatf("rd_vld on port %0d", p), want[p], rd_vld[p]);
        if (want[p]) begin
          check_data($sformatf("rd_dout on port %0d", p), want_data[p], rd_dout[p]);
        end
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("tests failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    for (int p = 0; p < `MP_NUMWRPT; p++) wr_req[p] = '0;
    for (int p = 0; p < `MP_NUMRDPT; p++) rd_req[p] = '0;
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      for (int row = 0; row < `MP_NUMVROW; row++) begin
        ref_mem[b][row] = '0;
      end
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    test_clear();
    test_basic();
    test_parallel();
    test_priority();
    test_rdw_back_to_back();
    test_random();
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/mp_bank_array.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_bank_array (
  input  wire logic                   clk,
  input  wire logic                   ready,
  input  mp_port_pkg::bank_wr_t       bank_wr [`MP_NUMVBNK],
  input  mp_port_pkg::rd_req_t        rd_req [`MP_NUMRDPT],
  output mp_mem_pkg::data_t           bank_dout [`MP_NUMRDPT][`MP_NUMVBNK]
);

  logic [`MP_NUMVBNK-1:0] rd_en [`MP_NUMRDPT];

  // One copy of every bank per read port; writes go to all copies.
  for (genvar p = 0; p < `MP_NUMRDPT; p++) begin : g_port
    for (genvar b = 0; b < `MP_NUMVBNK; b++) begin : g_bank
      assign rd_en[p][b] = ready && rd_req[p].read &&
                           (rd_req[p].bank == mp_mem_pkg::bank_t'(b));

      mp_sram_1r1w u_sram (
        .clk     (clk),
        .wr_en   (bank_wr[b].en),
        .wr_row  (bank_wr[b].row),
        .wr_data (bank_wr[b].data),
        .rd_en   (rd_en[p][b]),
        .rd_row  (rd_req[p].row),
        .rd_data (bank_dout[p][b])
      );
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mp_mem_config.svh ====
`ifndef MP_MEM_CONFIG_SVH
`define MP_MEM_CONFIG_SVH

// Data word width in bits.
`define MP_WIDTH 16

// Number of banks and the width of a bank address.
`define MP_NUMVBNK 4
`define MP_BITVBNK 2

// Rows in each bank and the width of a row address.
`define MP_NUMVROW 16
`define MP_BITVROW 4

// Write ports.
`define MP_NUMWRPT 2

// Read ports, each with its own replica of every bank.
`define MP_NUMRDPT 2

`endif

// ==== verilog/mp_mem_pkg.sv ====
`default_nettype none

`include "mp_mem_config.svh"

package mp_mem_pkg;

  // One stored word.
  typedef logic [`MP_WIDTH-1:0] data_t;

  // Bank select.
  typedef logic [`MP_BITVBNK-1:0] bank_t;

  // Row within a bank.
  typedef logic [`MP_BITVROW-1:0] row_t;

  // Clear machine. Zeroes all rows after reset, then serves requests.
  typedef enum logic {
    clearing = 1'b0,
    running  = 1'b1
  } clr_state_t;

endpackage

`default_nettype wire

// ==== verilog/mp_mem_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_mem_top (
  input  wire logic                   clk,
  input  wire logic                   reset,
  output logic                        ready,
  input  mp_port_pkg::wr_req_t        wr_req [`MP_NUMWRPT],
  input  mp_port_pkg::rd_req_t        rd_req [`MP_NUMRDPT],
  output logic [`MP_NUMRDPT-1:0]      rd_vld,
  output mp_mem_pkg::data_t           rd_dout [`MP_NUMRDPT]
);

  mp_port_pkg::bank_wr_t bank_wr [`MP_NUMVBNK];
  mp_mem_pkg::data_t     bank_dout [`MP_NUMRDPT][`MP_NUMVBNK];

  mp_write_steer u_write_steer (
    .clk     (clk),
    .reset   (reset),
    .wr_req  (wr_req),
    .ready   (ready),
    .bank_wr (bank_wr)
  );

  mp_bank_array u_bank_array (
    .clk       (clk),
    .ready     (ready),
    .bank_wr   (bank_wr),
    .rd_req    (rd_req),
    .bank_dout (bank_dout)
  );

  mp_read_return u_read_return (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .rd_req    (rd_req),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

`default_nettype wire

// ==== verilog/mp_port_pkg.sv ====
`default_nettype none

package mp_port_pkg;

  // Request on one write port.
  typedef struct packed {
    logic              write;
    mp_mem_pkg::bank_t bank;
    mp_mem_pkg::row_t  row;
    mp_mem_pkg::data_t data;
  } wr_req_t;

  // Request on one read port.
  typedef struct packed {
    logic              read;
    mp_mem_pkg::bank_t bank;
    mp_mem_pkg::row_t  row;
  } rd_req_t;

  // Resolved write command for one bank, sent to all of its replicas.
  typedef struct packed {
    logic              en;
    mp_mem_pkg::row_t  row;
    mp_mem_pkg::data_t data;
  } bank_wr_t;

endpackage

`default_nettype wire

// ==== verilog/mp_read_return.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_read_return (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   ready,
  input  mp_port_pkg::rd_req_t        rd_req [`MP_NUMRDPT],
  input  mp_mem_pkg::data_t           bank_dout [`MP_NUMRDPT][`MP_NUMVBNK],
  output logic [`MP_NUMRDPT-1:0]      rd_vld,
  output mp_mem_pkg::data_t           rd_dout [`MP_NUMRDPT]
);

  logic [`MP_NUMRDPT-1:0] rd_pend;
  mp_mem_pkg::bank_t      rd_bank [`MP_NUMRDPT];

  // First stage tracks the SRAM read in flight.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend <= '0;
    end else begin
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        rd_pend[p] <= ready && rd_req[p].read;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_bank[p] <= rd_req[p].bank;
    end
  end

  // Second stage picks the addressed bank copy.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= rd_pend;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      if (rd_pend[p]) begin
        rd_dout[p] <= bank_dout[p][rd_bank[p]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mp_sram_1r1w.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_sram_1r1w (
  input  wire logic               clk,
  input  wire logic               wr_en,
  input  mp_mem_pkg::row_t        wr_row,
  input  mp_mem_pkg::data_t       wr_data,
  input  wire logic               rd_en,
  input  mp_mem_pkg::row_t        rd_row,
  output mp_mem_pkg::data_t       rd_data
);

  mp_mem_pkg::data_t mem [`MP_NUMVROW];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // Read-first. A same-edge write lands after the old word is captured.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mp_write_steer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "mp_mem_config.svh"

module mp_write_steer (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  mp_port_pkg::wr_req_t        wr_req [`MP_NUMWRPT],
  output logic                        ready,
  output mp_port_pkg::bank_wr_t       bank_wr [`MP_NUMVBNK]
);

  mp_mem_pkg::clr_state_t state;
  mp_mem_pkg::row_t       clr_row;

  // Clear machine. One row per cycle, all banks at once.
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= mp_mem_pkg::clearing;
      clr_row <= '0;
    end else if (state == mp_mem_pkg::clearing) begin
      clr_row <= clr_row + 1'b1;
      if (clr_row == mp_mem_pkg::row_t'(`MP_NUMVROW - 1)) begin
        state <= mp_mem_pkg::running;
      end
    end
  end

  assign ready = (state == mp_mem_pkg::running);

  // Per-bank write arbitration.
  always_comb begin
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      bank_wr[b] = '0;
      if (state == mp_mem_pkg::clearing) begin
        bank_wr[b].en   = 1'b1;
        bank_wr[b].row  = clr_row;
        bank_wr[b].data = '0;
      end else begin
        // Scan from the highest port down so the lowest matching port is kept.
        for (int p = `MP_NUMWRPT - 1; p >= 0; p--) begin
          if (wr_req[p].write && (wr_req[p].bank == mp_mem_pkg::bank_t'(b))) begin
            bank_wr[b].en   = 1'b1;
            bank_wr[b].row  = wr_req[p].row;
            bank_wr[b].data = wr_req[p].data;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
